// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP       ?= tb_stream_source
FILELIST  ?= stream_source_top.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: src_addr_gen.sv
/*
  One byte address per beat, base plus stride times index.
  Base, stride and count are sampled on start; ctrl may change afterwards.
  A count of zero produces no address and no last pulse.
  The address wraps silently at 2^32.
*/
`timescale 1ns/1ps
`include "stream_source_macros.svh"

module src_addr_gen (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          enable_i,
  input  logic                          start_i,
  input  stream_source_pkg::src_ctrl_t  ctrl_i,
  input  logic                          addr_ready_i,
  output logic [`SRC_ADDR_W-1:0]        addr_o,
  output logic                          addr_valid_o,
  output logic                          last_o
);

  logic [`SRC_ADDR_W-1:0] addr_q;
  logic [`SRC_CNT_W-1:0]  stride_q;
  logic [`SRC_CNT_W-1:0]  rem_q; // addresses still to hand out
  logic                   take;

  assign addr_valid_o = (rem_q != '0);
  assign take         = addr_valid_o & addr_ready_i; // ready already carries enable
  assign addr_o       = addr_q;
  assign last_o       = take & (rem_q == `SRC_CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q <= '0;
    end else if (clear_i) begin
      rem_q <= '0;
    end else if (enable_i) begin
      if (start_i) begin
        rem_q <= ctrl_i.tot_len;
      end else if (take) begin
        rem_q <= rem_q - 1'b1;
      end
    end
  end

  // payload, only meaningful while rem_q is nonzero
  always_ff @(posedge clk_i) begin
    if (enable_i && !clear_i) begin
      if (start_i) begin
        addr_q   <= ctrl_i.base_addr;
        stride_q <= ctrl_i.stride;
      end else if (take) begin
        addr_q <= addr_q + {{(`SRC_ADDR_W - `SRC_CNT_W){1'b0}}, stride_q};
      end
    end
  end

  // an offered address is withdrawn only by a take or an abort
  a_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(addr_valid_o) |-> $past(addr_ready_i || clear_i));

endmodule

// File: src_mem_issue.sv
/*
  Issues word-aligned reads and tracks the byte offset of each one.
  A request is raised only while the output is ready, so at most one
  returned word ever has to wait in the output hold register.
  The offset queue assumes read data exactly one cycle after the grant;
  longer latency needs a deeper queue.
*/
`timescale 1ns/1ps
`include "stream_source_macros.svh"

module src_mem_issue (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            enable_i,
  input  logic                            active_i,
  input  logic [`SRC_ADDR_W-1:0]          addr_i,
  input  logic                            addr_valid_i,
  output logic                            addr_ready_o,
  input  logic                            beat_ready_i,
  output stream_source_pkg::src_mem_req_t mem_req_o,
  input  logic                            mem_gnt_i,
  output logic [1:0]                      ofs_o,
  output logic                            ofs_valid_o,
  input  logic                            pop_i
);

  logic [1:0]                ofs_mem [`SRC_OFS_DEPTH];
  logic [`SRC_OFS_PTR_W-1:0] wr_ptr_q;
  logic [`SRC_OFS_PTR_W-1:0] rd_ptr_q;
  logic [`SRC_OFS_PTR_W:0]   ofs_cnt_q;
  logic                      req;
  logic                      push;

  function automatic logic [`SRC_OFS_PTR_W-1:0] ptr_inc(
    input logic [`SRC_OFS_PTR_W-1:0] ptr
  );
    return (ptr == `SRC_OFS_PTR_W'(`SRC_OFS_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // no new read in the abort cycle, so nothing returns after it
  assign req  = enable_i & ~clear_i & active_i & addr_valid_i & beat_ready_i;
  assign push = req & mem_gnt_i;

  assign mem_req_o.req  = req;
  assign mem_req_o.addr = {addr_i[`SRC_ADDR_W-1:2], 2'b00};
  assign addr_ready_o   = push;

  assign ofs_o       = ofs_mem[rd_ptr_q];
  assign ofs_valid_o = (ofs_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      ofs_mem[wr_ptr_q] <= addr_i[1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      ofs_cnt_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      ofs_cnt_q <= '0;
    end else if (enable_i) begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop_i})
        2'b10:   ofs_cnt_q <= ofs_cnt_q + 1'b1;
        2'b01:   ofs_cnt_q <= ofs_cnt_q - 1'b1;
        default: ofs_cnt_q <= ofs_cnt_q;
      endcase
    end
  end

  a_ofs_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push && !pop_i) |-> (ofs_cnt_q < `SRC_OFS_DEPTH));

  // the output side must never consume an offset that was not issued
  a_ofs_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> ofs_valid_o);

endmodule

// File: src_realign_out.sv
/*
  Realigns each returned word to the byte offset of its address and
  drives the output beat. Returned data passes straight through; if the
  sink is not ready it waits in a single hold register.
  enable_i must stay high while a read is in flight, or the word is lost.
*/
`timescale 1ns/1ps
`include "stream_source_macros.svh"

module src_realign_out (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            enable_i,
  input  stream_source_pkg::src_mem_rsp_t mem_rsp_i,
  input  logic [1:0]                      ofs_i,
  input  logic                            ofs_valid_i,
  output logic                            pop_o,
  input  logic                            beat_ready_i,
  output stream_source_pkg::src_beat_t    beat_o,
  input  logic [`SRC_CNT_W-1:0]           tot_len_i,
  input  logic                            cnt_clr_i,
  output logic                            all_sent_o
);

  stream_source_pkg::src_rdata_u sel_u;
  logic [`SRC_MEM_W-1:0]         hold_data_q;
  logic                          hold_valid_q;
  logic [`SRC_CNT_W-1:0]         cnt_q; // beats transferred in this run
  logic                          xfer;

  assign sel_u.word = mem_rsp_i.r_valid ? mem_rsp_i.r_data : hold_data_q;

  // bytes ofs .. ofs+3 of the selected word
  always_comb begin
    beat_o.data = '0;
    for (int i = 0; i < `SRC_BEAT_W / 8; i++) begin
      beat_o.data[8*i +: 8] = sel_u.bytes[3'(ofs_i) + 3'(i)];
    end
  end

  assign beat_o.valid = enable_i & ~clear_i & (mem_rsp_i.r_valid | hold_valid_q);
  assign xfer         = beat_o.valid & beat_ready_i;
  assign pop_o        = xfer; // offset leaves with its beat
  assign all_sent_o   = (cnt_q == tot_len_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (enable_i) begin
      if (mem_rsp_i.r_valid && !beat_ready_i) begin
        hold_valid_q <= 1'b1;
      end else if (xfer) begin
        hold_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enable_i && mem_rsp_i.r_valid && !beat_ready_i) begin
      hold_data_q <= mem_rsp_i.r_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || cnt_clr_i) begin
      cnt_q <= '0;
    end else if (xfer) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // every returning word needs the offset of its request
  a_rsp_has_ofs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_i.r_valid |-> ofs_valid_i);

endmodule

// File: stream_source_macros.svh
/*
  Widths and sizes of the read streamer.
  The memory port is fixed at 64 bits of read data and 32-bit beats.
  SRC_OFS_DEPTH must cover every request in flight. With one cycle of
  read latency two entries are enough, and the rest is margin.
  SRC_OFS_PTR_W must equal clog2 of SRC_OFS_DEPTH.
*/
`ifndef STREAM_SOURCE_MACROS_SVH
`define STREAM_SOURCE_MACROS_SVH

`define SRC_ADDR_W 32 // byte address
`define SRC_BEAT_W 32 // output beat
`define SRC_MEM_W 64 // addressed word plus the next one
`define SRC_CNT_W 16 // beat count, stride and counters

`define SRC_OFS_DEPTH 4 // offsets in flight
`define SRC_OFS_PTR_W 2 // clog2 of the depth

`endif

// File: stream_source_pkg.sv
/*
  Types shared by the read streamer and its testbench.
  Stride and beat count are unsigned, so addresses only move upward.
  The read word is little endian: byte 0 is the addressed byte.
*/
`include "stream_source_macros.svh"

package stream_source_pkg;

  typedef struct packed {
    logic [`SRC_ADDR_W-1:0] base_addr; // first byte address
    logic [`SRC_CNT_W-1:0]  stride; // bytes between beats
    logic [`SRC_CNT_W-1:0]  tot_len; // beats per run
  } src_ctrl_t;

  typedef struct packed {
    logic ready_start;
    logic done;
  } src_flags_t;

  typedef struct packed {
    logic                   req;
    logic [`SRC_ADDR_W-1:0] addr; // low two bits always zero
  } src_mem_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  r_valid;
    logic [`SRC_MEM_W-1:0] r_data;
  } src_mem_rsp_t;

  // same read word, whole or byte by byte
  typedef union packed {
    logic [`SRC_MEM_W-1:0]           word;
    logic [`SRC_MEM_W/8-1:0][7:0]    bytes;
  } src_rdata_u;

  typedef struct packed {
    logic                   valid;
    logic [`SRC_BEAT_W-1:0] data;
  } src_beat_t;

  typedef enum logic [1:0] {
    IDLE,
    WORKING,
    DRAIN
  } src_state_e;

endpackage

// File: stream_source_top.f
+incdir+.
stream_source_pkg.sv
src_addr_gen.sv
src_mem_issue.sv
src_realign_out.sv
stream_source_top.sv
tb_mem_model.sv
tb_stream_source.sv

// File: stream_source_top.sv
/*
  Read streamer for a single-cycle memory port.
  ctrl_i.tot_len must stay stable from start until done.
  start_i is ignored unless ready_start is high.
  clear_i aborts at once; a word returning in that cycle is dropped.
  enable_i low freezes every register.
*/
`timescale 1ns/1ps
`include "stream_source_macros.svh"

module stream_source_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            enable_i,
  input  stream_source_pkg::src_ctrl_t    ctrl_i,
  input  logic                            start_i,
  output stream_source_pkg::src_mem_req_t mem_req_o,
  input  stream_source_pkg::src_mem_rsp_t mem_rsp_i,
  output stream_source_pkg::src_beat_t    beat_o,
  input  logic                            beat_ready_i,
  output stream_source_pkg::src_flags_t   flags_o
);

  stream_source_pkg::src_state_e state_q, state_d;
  logic [`SRC_ADDR_W-1:0]        addr;
  logic                          addr_valid, addr_ready, addr_last;
  logic [1:0]                    ofs;
  logic                          ofs_valid, ofs_pop;
  logic                          gen_start, cnt_clr, all_sent;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= stream_source_pkg::IDLE;
    end else if (clear_i) begin
      state_q <= stream_source_pkg::IDLE;
    end else if (enable_i) begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d             = state_q;
    gen_start           = 1'b0;
    cnt_clr             = 1'b0;
    flags_o.ready_start = 1'b0;
    flags_o.done        = 1'b0;
    case (state_q)
      stream_source_pkg::IDLE: begin
        flags_o.ready_start = 1'b1;
        if (start_i) begin
          state_d   = stream_source_pkg::WORKING;
          gen_start = enable_i;
        end
      end
      stream_source_pkg::WORKING: begin
        if (addr_last) state_d = stream_source_pkg::DRAIN;
      end
      stream_source_pkg::DRAIN: begin
        if (all_sent) begin // last beat went out a cycle ago
          state_d      = stream_source_pkg::IDLE;
          flags_o.done = enable_i;
          cnt_clr      = enable_i;
        end
      end
      default: state_d = stream_source_pkg::IDLE;
    endcase
  end

  src_addr_gen i_addr_gen (
    .clk_i, .rst_ni, .clear_i, .enable_i,
    .start_i      ( gen_start  ),
    .ctrl_i,
    .addr_ready_i ( addr_ready ),
    .addr_o       ( addr       ),
    .addr_valid_o ( addr_valid ),
    .last_o       ( addr_last  )
  );

  src_mem_issue i_mem_issue (
    .clk_i, .rst_ni, .clear_i, .enable_i,
    .active_i     ( state_q != stream_source_pkg::IDLE ),
    .addr_i       ( addr          ),
    .addr_valid_i ( addr_valid    ),
    .addr_ready_o ( addr_ready    ),
    .beat_ready_i,
    .mem_req_o,
    .mem_gnt_i    ( mem_rsp_i.gnt ),
    .ofs_o        ( ofs           ),
    .ofs_valid_o  ( ofs_valid     ),
    .pop_i        ( ofs_pop       )
  );

  src_realign_out i_realign_out (
    .clk_i, .rst_ni, .clear_i, .enable_i,
    .mem_rsp_i,
    .ofs_i        ( ofs            ),
    .ofs_valid_i  ( ofs_valid      ),
    .pop_o        ( ofs_pop        ),
    .beat_ready_i,
    .beat_o,
    .tot_len_i    ( ctrl_i.tot_len ),
    .cnt_clr_i    ( cnt_clr        ),
    .all_sent_o   ( all_sent       )
  );

endmodule

// File: tb_mem_model.sv
/*
  Byte memory for the streamer testbench, 1 KiB, filled once at time zero.
  Every request is granted in its own cycle and the 64-bit read data
  follows one cycle later. Addresses wrap modulo the memory size, so
  only the low 10 address bits select a byte.
*/
`timescale 1ns/1ps
`include "stream_source_macros.svh"

module tb_mem_model (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  stream_source_pkg::src_mem_req_t req_i,
  output stream_source_pkg::src_mem_rsp_t rsp_o
);

  localparam int unsigned mem_size = 1024;

  logic [7:0]                    bytes_q [mem_size];
  logic                          r_valid_q;
  logic [`SRC_MEM_W-1:0]         r_data_q;
  stream_source_pkg::src_rdata_u word_u;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one xorshift step per byte, so each byte depends on its full index
  initial begin
    logic [31:0] state;
    int          i;
    state = 32'he1f1;
    for (i = 0; i < mem_size; i++) begin
      state = xorshift32(state);
      bytes_q[i] = state[7:0];
    end
  end

  // addressed byte lands in byte 0
  always_comb begin
    for (int b = 0; b < `SRC_MEM_W / 8; b++) begin
      word_u.bytes[b] = bytes_q[req_i.addr[9:0] + 10'(b)];
    end
  end

  assign rsp_o.gnt     = req_i.req; // always granted at once
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_data  = r_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req & rsp_o.gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      r_data_q <= word_u.word;
    end
  end

endmodule

// File: tb_stream_source.sv
/*
  Testbench for the read streamer against a 1 KiB byte memory model.
  Each table row starts one stream; every beat is compared with the
  memory bytes at base + stride * index, little endian.
  enable_i stays high for the whole run. Stops at the first mismatch.
*/
`timescale 1ns/1ps
`include "stream_source_macros.svh"

module tb_stream_source;

  typedef struct packed {
    logic [`SRC_ADDR_W-1:0] base_addr;
    logic [`SRC_CNT_W-1:0]  stride;
    logic [`SRC_CNT_W-1:0]  tot_len;
    logic                   rand_ready; // sink ready from xorshift
    logic                   mid_clear; // abort halfway through
  } stim_row_t;

  localparam int num_rows  = 8;
  localparam int run_limit = 2000; // cycles allowed per row

  logic                            clk_i;
  logic                            rst_ni;
  logic                            clear;
  logic                            enable;
  logic                            start;
  logic                            beat_ready;
  stream_source_pkg::src_ctrl_t    ctrl;
  stream_source_pkg::src_mem_req_t mem_req;
  stream_source_pkg::src_mem_rsp_t mem_rsp;
  stream_source_pkg::src_beat_t    beat;
  stream_source_pkg::src_flags_t   flags;
  stim_row_t                       rows [num_rows];
  logic [31:0]                     rnd_q;

  stream_source_top stream_source_top_i (
    .clk_i, .rst_ni,
    .clear_i      ( clear      ),
    .enable_i     ( enable     ),
    .ctrl_i       ( ctrl       ),
    .start_i      ( start      ),
    .mem_req_o    ( mem_req    ),
    .mem_rsp_i    ( mem_rsp    ),
    .beat_o       ( beat       ),
    .beat_ready_i ( beat_ready ),
    .flags_o      ( flags      )
  );

  tb_mem_model mem_i (
    .clk_i, .rst_ni,
    .req_i ( mem_req ),
    .rsp_o ( mem_rsp )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic stream_source_pkg::src_flags_t make_flags(input logic rs, input logic dn);
    return '{ready_start: rs, done: dn};
  endfunction

  function automatic stream_source_pkg::src_beat_t make_beat(
    input logic                   v,
    input logic [`SRC_BEAT_W-1:0] d
  );
    return '{valid: v, data: d};
  endfunction

  // four bytes from base + stride * idx, memory index is the low 10 bits
  function automatic logic [`SRC_BEAT_W-1:0] expected_word(
    input stream_source_pkg::src_ctrl_t c,
    input logic [`SRC_CNT_W-1:0]        idx
  );
    logic [`SRC_ADDR_W-1:0] a;
    logic [`SRC_BEAT_W-1:0] w;
    int                     j;
    a = c.base_addr + 32'(c.stride) * 32'(idx);
    for (j = 0; j < `SRC_BEAT_W / 8; j++) begin
      w[8*j +: 8] = mem_i.bytes_q[a[9:0] + 10'(j)];
    end
    return w;
  endfunction

  task automatic stop_with_failure(input string what);
    $display("Simulation FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic check_beat(
    input stream_source_pkg::src_beat_t got,
    input stream_source_pkg::src_beat_t exp,
    input logic [`SRC_CNT_W-1:0]        idx
  );
    if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
      $display("error @ %0d ns: beat %0d got valid %0b data %08h, expected valid %0b data %08h",
               $time, idx, got.valid, got.data, exp.valid, exp.data);
      stop_with_failure("output beat does not match the memory contents");
    end
  endtask

  task automatic check_flags(
    input stream_source_pkg::src_flags_t got,
    input stream_source_pkg::src_flags_t exp,
    input string                         what
  );
    if (got !== exp) begin
      $display("error @ %0d ns: flags %s got ready_start %0b done %0b, expected %0b %0b",
               $time, what, got.ready_start, got.done, exp.ready_start, exp.done);
      stop_with_failure("status flags are wrong");
    end
  endtask

  // base, stride, tot_len, rand_ready, mid_clear
  task automatic load_table();
    rows[0] = '{32'h0000_0040, 16'd4, 16'd8, 1'b0, 1'b0}; // aligned, contiguous
    rows[1] = '{32'h0000_0101, 16'd5, 16'd6, 1'b0, 1'b0};
    rows[2] = '{32'h0000_0202, 16'd7, 16'd6, 1'b0, 1'b0};
    rows[3] = '{32'h0000_0303, 16'd3, 16'd7, 1'b0, 1'b0};
    rows[4] = '{32'h0000_0011, 16'd9, 16'd12, 1'b1, 1'b0};
    rows[5] = '{32'h1000_03f1, 16'd4, 16'd10, 1'b1, 1'b0}; // wraps the model
    rows[6] = '{32'h0000_0020, 16'd13, 16'd16, 1'b1, 1'b1};
    rows[7] = '{32'h0000_0006, 16'd1, 16'd9, 1'b1, 1'b0};
  endtask

  task automatic run_row(input stim_row_t r);
    stream_source_pkg::src_ctrl_t c;
    logic [`SRC_CNT_W-1:0]        k;
    int                           cycles;
    int                           quiet;
    int                           q;
    logic                         rdy;
    logic                         clr;
    logic                         held;
    logic                         done_due;
    logic                         fin;
    c = '{base_addr: r.base_addr, stride: r.stride, tot_len: r.tot_len};
    k = '0;
    cycles = 0;
    held = 1'b0;
    done_due = 1'b0;
    fin = 1'b0;
    @(negedge clk_i);
    ctrl = c;
    start = 1'b1;
    beat_ready = 1'b1;
    #1;
    check_flags(flags, make_flags(1'b1, 1'b0), "before start");
    check_beat(beat, make_beat(1'b0, '0), k);
    while (!fin) begin
      if (cycles >= run_limit) begin
        stop_with_failure("timeout waiting for the stream to finish");
      end
      cycles++;
      rdy = 1'b1;
      if (r.rand_ready) begin
        rnd_q = xorshift32(rnd_q);
        rdy = (rnd_q[7:0] < 8'd160);
      end
      clr = r.mid_clear & (k == (r.tot_len >> 1));
      @(negedge clk_i);
      start = 1'b0;
      beat_ready = rdy;
      clear = clr;
      #1;
      check_flags(flags, make_flags(1'b0, done_due), "while streaming");
      if (clr || done_due) begin
        check_beat(beat, make_beat(1'b0, '0), k); // masked on abort, idle after done
        fin = 1'b1;
      end else begin
        if (beat.valid || held) begin
          check_beat(beat, make_beat(1'b1, expected_word(c, k)), k);
        end
        held = beat.valid & ~rdy; // must stay put until taken
        if (beat.valid && rdy) begin
          k = k + 16'd1;
          done_due = (k == r.tot_len);
        end
      end
    end
    quiet = r.mid_clear ? 8 : 1;
    for (q = 0; q < quiet; q++) begin
      @(negedge clk_i);
      clear = 1'b0;
      beat_ready = 1'b1;
      #1;
      check_flags(flags, make_flags(1'b1, 1'b0), "after the run");
      check_beat(beat, make_beat(1'b0, '0), k);
    end
  endtask

  initial begin
    int i;
    rst_ni = 1'b0;
    clear = 1'b0;
    enable = 1'b1;
    start = 1'b0;
    beat_ready = 1'b0;
    ctrl = '0;
    rnd_q = 32'he1f1;
    load_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_flags(flags, make_flags(1'b1, 1'b0), "after reset");
    check_beat(beat, make_beat(1'b0, '0), '0);
    for (i = 0; i < num_rows; i++) begin
      run_row(rows[i]);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule
